/* verilog/camera_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the raw-to-RGB
// camera front end. Import into each module header
// with a wildcard import.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package camera_pkg;

    localparam int PIXEL_WIDTH     = 10;                     // Raw and colour sample bits
    localparam int PIXEL_MAX       = (1 << PIXEL_WIDTH) - 1; // Saturation level
    localparam int COORD_WIDTH     = 11;
    localparam int COUNT_WIDTH     = 22;                     // Frame statistics counters
    localparam int DARK_LEVEL      = 64;                     // Applies to the upper 8 bits
    localparam int MAX_LINE        = 1024;                   // Debayer line buffer depth
    localparam int LINE_ADDR_WIDTH = $clog2(MAX_LINE);

    typedef struct packed {
        logic [PIXEL_WIDTH-1:0] red;
        logic [PIXEL_WIDTH-1:0] green;
        logic [PIXEL_WIDTH-1:0] blue;
    } rgb_t;

    // Raw Bayer stream, RGGB order
    typedef struct packed {
        logic                   frame_valid;
        logic                   line_valid;
        logic                   pixel_valid;
        logic [PIXEL_WIDTH-1:0] data;
    } bayer_stream_t;

    typedef struct packed {
        logic frame_valid;
        logic line_valid;
        logic pixel_valid;
        rgb_t pixel;
    } rgb_stream_t;

    // Columns x_start to x_end-1, lines y_start to y_end-1
    typedef struct packed {
        logic [COORD_WIDTH-1:0] x_start;
        logic [COORD_WIDTH-1:0] x_end;
        logic [COORD_WIDTH-1:0] y_start;
        logic [COORD_WIDTH-1:0] y_end;
    } crop_window_t;

    typedef struct packed {
        logic [COUNT_WIDTH-1:0] pixel_count;
        logic [COUNT_WIDTH-1:0] dark_count;
    } frame_stats_t;

endpackage

/* verilog/crop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Window crop on a video stream. Used for both the
// raw pan crop and the RGB zoom crop; the payload
// type is set per instance. One cycle of latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module crop
    import camera_pkg::*;
#(
    parameter type payload_t = logic [PIXEL_WIDTH-1:0]
) (
    input  logic         mipi_byte_clock,
    input  logic         mipi_byte_reset_n,

    input  crop_window_t window_i,

    input  logic         frame_valid_i,
    input  logic         line_valid_i,
    input  logic         pixel_valid_i,
    input  payload_t     data_i,

    output logic         frame_valid_o,
    output logic         line_valid_o,
    output logic         pixel_valid_o,
    output payload_t     data_o
);

    logic [COORD_WIDTH-1:0] x_count;    // Pixels seen so far on this line
    logic [COORD_WIDTH-1:0] y_count;    // Lines completed in this frame
    logic                   line_valid_d;
    logic                   line_end;
    logic                   x_inside;
    logic                   y_inside;

    assign line_end = line_valid_d & ~line_valid_i;
    assign x_inside = (x_count >= window_i.x_start) && (x_count < window_i.x_end);
    assign y_inside = (y_count >= window_i.y_start) && (y_count < window_i.y_end);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count       <= '0;
            y_count       <= '0;
            line_valid_d  <= 1'b0;
            frame_valid_o <= 1'b0;
            line_valid_o  <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            line_valid_d <= line_valid_i;

            if (!line_valid_i) begin
                x_count <= '0;                      // Line over
            end else if (pixel_valid_i) begin
                x_count <= x_count + 1'b1;
            end

            if (!frame_valid_i) begin
                y_count <= '0;                      // Frame over
            end else if (line_end) begin
                y_count <= y_count + 1'b1;
            end

            frame_valid_o <= frame_valid_i;
            line_valid_o  <= line_valid_i & x_inside & y_inside;
            pixel_valid_o <= pixel_valid_i & x_inside & y_inside;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_o <= data_i;
    end

    // Upstream must keep pixel strobes inside a line
    pixel_in_line_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        pixel_valid_i |-> line_valid_i
    ) else $error("crop: pixel_valid without line_valid");

endmodule

/* verilog/debayer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2x2 binning debayer for an RGGB stream. Stores
// the even line, then emits one RGB pixel per quad
// on the odd line, one cycle after its last sample.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module debayer
    import camera_pkg::*;
(
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,

    input  bayer_stream_t bayer_i,
    output rgb_stream_t   rgb_o
);

    logic [COORD_WIDTH-1:0]     x_count;   // Column of the next sample
    logic                       line_valid_d;
    logic                       line_end;
    logic                       line_odd;   // G B line of the quad

    logic [PIXEL_WIDTH-1:0]     line_buf [MAX_LINE];
    logic [LINE_ADDR_WIDTH-1:0] buf_addr;
    logic [PIXEL_WIDTH-1:0]     buf_rdata;

    logic [PIXEL_WIDTH-1:0]     red_hold;
    logic [PIXEL_WIDTH-1:0]     green_hold;
    logic [PIXEL_WIDTH:0]       green_sum;
    logic                       quad_done;

    logic                       frame_valid_q;
    logic                       line_valid_q;
    logic                       pixel_valid_q;
    rgb_t                       pixel_q;

    assign line_end  = line_valid_d & ~bayer_i.line_valid;
    assign buf_addr  = x_count[LINE_ADDR_WIDTH-1:0];
    assign buf_rdata = line_buf[buf_addr];
    assign green_sum = {1'b0, buf_rdata} + {1'b0, green_hold};
    assign quad_done = bayer_i.pixel_valid & line_odd & x_count[0];

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count       <= '0;
            line_valid_d  <= 1'b0;
            line_odd      <= 1'b0;
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            pixel_valid_q <= 1'b0;
        end else begin
            line_valid_d <= bayer_i.line_valid;

            if (!bayer_i.line_valid) begin
                x_count <= '0;
            end else if (bayer_i.pixel_valid) begin
                x_count <= x_count + 1'b1;
            end

            // First window line is always the R G line
            if (!bayer_i.frame_valid) begin
                line_odd <= 1'b0;
            end else if (line_end) begin
                line_odd <= ~line_odd;
            end

            frame_valid_q <= bayer_i.frame_valid;
            line_valid_q  <= bayer_i.line_valid & line_odd;
            pixel_valid_q <= quad_done;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (bayer_i.pixel_valid && !line_odd) begin
            line_buf[buf_addr] <= bayer_i.data;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (bayer_i.pixel_valid && line_odd && !x_count[0]) begin
            red_hold   <= buf_rdata;            // R from the line above
            green_hold <= bayer_i.data;         // G of the odd line
        end
        if (quad_done) begin
            pixel_q.red   <= red_hold;
            pixel_q.green <= green_sum[PIXEL_WIDTH:1];
            pixel_q.blue  <= bayer_i.data;
        end
    end

    assign rgb_o = '{
        frame_valid: frame_valid_q,
        line_valid:  line_valid_q,
        pixel_valid: pixel_valid_q,
        pixel:       pixel_q
    };

    // The pan window must fit the line buffer
    line_fits_buffer_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        bayer_i.pixel_valid |-> (x_count < MAX_LINE)
    ) else $error("debayer: line longer than %0d pixels", MAX_LINE);

endmodule

/* verilog/metering.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame metering on the cropped raw stream. Counts
// all pixels and dark pixels, and publishes both one
// cycle after frame_valid falls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module metering
    import camera_pkg::*;
(
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,

    input  bayer_stream_t bayer_i,

    output frame_stats_t  stats_o,
    output logic          stats_valid_o
);

    logic                   frame_valid_d;
    logic                   frame_start;
    logic                   frame_end;
    logic                   dark;
    logic [COUNT_WIDTH-1:0] pixel_count;
    logic [COUNT_WIDTH-1:0] dark_count;

    assign frame_start = bayer_i.frame_valid & ~frame_valid_d;
    assign frame_end   = ~bayer_i.frame_valid & frame_valid_d;
    assign dark        = bayer_i.data[PIXEL_WIDTH-1 -: 8] < DARK_LEVEL;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_d <= 1'b0;
            pixel_count   <= '0;
            dark_count    <= '0;
            stats_o       <= '0;
            stats_valid_o <= 1'b0;
        end else begin
            frame_valid_d <= bayer_i.frame_valid;

            if (frame_start) begin
                // A first pixel may share the restart cycle
                pixel_count <= COUNT_WIDTH'(bayer_i.pixel_valid);
                dark_count  <= COUNT_WIDTH'(bayer_i.pixel_valid & dark);
            end else if (bayer_i.pixel_valid) begin
                pixel_count <= pixel_count + 1'b1;
                if (dark) begin
                    dark_count <= dark_count + 1'b1;
                end
            end

            stats_valid_o <= frame_end;
            if (frame_end) begin
                stats_o.pixel_count <= pixel_count;
                stats_o.dark_count  <= dark_count;
            end
        end
    end

    // Published record stays self-consistent
    dark_within_total_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        stats_valid_o |-> (stats_o.dark_count <= stats_o.pixel_count)
    ) else $error("metering: dark_count above pixel_count");

endmodule

/* verilog/digital_gain.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Digital gain of 1 or 2 with saturation. The factor
// is picked at each frame start from the latest
// metering record. One cycle of latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module digital_gain
    import camera_pkg::*;
(
    input  logic         mipi_byte_clock,
    input  logic         mipi_byte_reset_n,

    input  rgb_stream_t  rgb_i,
    input  frame_stats_t stats_i,
    input  logic         stats_valid_i,

    output rgb_stream_t  rgb_o
);

    frame_stats_t stats_q;
    frame_stats_t stats_sel;
    logic         frame_valid_d;
    logic         frame_start;
    logic         want_x2;
    logic         gain_x2;        // Low means unity gain
    logic         frame_valid_q;
    logic         line_valid_q;
    logic         pixel_valid_q;
    rgb_t         pixel_q;

    function automatic logic [PIXEL_WIDTH-1:0] double_sat(input logic [PIXEL_WIDTH-1:0] sample);
        logic [PIXEL_WIDTH:0] doubled;
        doubled = {sample, 1'b0};
        return doubled[PIXEL_WIDTH] ? PIXEL_WIDTH'(PIXEL_MAX) : doubled[PIXEL_WIDTH-1:0];
    endfunction

    assign frame_start = rgb_i.frame_valid & ~frame_valid_d;
    assign stats_sel   = stats_valid_i ? stats_i : stats_q;   // Newest record wins
    assign want_x2     = {stats_sel.dark_count, 1'b0} > {1'b0, stats_sel.pixel_count};

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            stats_q       <= '0;
            frame_valid_d <= 1'b0;
            gain_x2       <= 1'b0;
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            pixel_valid_q <= 1'b0;
        end else begin
            frame_valid_d <= rgb_i.frame_valid;
            if (stats_valid_i) begin
                stats_q <= stats_i;
            end
            if (frame_start) begin
                gain_x2 <= want_x2;
            end
            frame_valid_q <= rgb_i.frame_valid;
            line_valid_q  <= rgb_i.line_valid;
            pixel_valid_q <= rgb_i.pixel_valid;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (gain_x2) begin
            pixel_q.red   <= double_sat(rgb_i.pixel.red);
            pixel_q.green <= double_sat(rgb_i.pixel.green);
            pixel_q.blue  <= double_sat(rgb_i.pixel.blue);
        end else begin
            pixel_q <= rgb_i.pixel;
        end
    end

    assign rgb_o = '{
        frame_valid: frame_valid_q,
        line_valid:  line_valid_q,
        pixel_valid: pixel_valid_q,
        pixel:       pixel_q
    };

    // One gain for the whole frame
    gain_at_frame_start_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        !$stable(gain_x2) |-> $past(frame_start)
    ) else $error("digital_gain: gain changed inside a frame");

endmodule

/* verilog/camera_frontend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raw-to-RGB camera front end: pan crop, debayer and
// metering, digital gain, then zoom crop. Windows
// come in as ports; everything runs on the byte clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module camera_frontend
    import camera_pkg::*;
(
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,

    input  bayer_stream_t bayer_i,
    input  crop_window_t  pan_window_i,
    input  crop_window_t  zoom_window_i,

    output rgb_stream_t   rgb_o,
    output frame_stats_t  stats_o,
    output logic          stats_valid_o
);

    logic                   pan_frame_valid;
    logic                   pan_line_valid;
    logic                   pan_pixel_valid;
    logic [PIXEL_WIDTH-1:0] pan_data;
    bayer_stream_t          pan_stream;

    rgb_stream_t            debayer_rgb;
    rgb_stream_t            gain_rgb;

    logic                   zoom_frame_valid;
    logic                   zoom_line_valid;
    logic                   zoom_pixel_valid;
    rgb_t                   zoom_pixel;

    crop #(
        .payload_t(logic [PIXEL_WIDTH-1:0])
    ) pan_crop (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .window_i         (pan_window_i),
        .frame_valid_i    (bayer_i.frame_valid),
        .line_valid_i     (bayer_i.line_valid),
        .pixel_valid_i    (bayer_i.pixel_valid),
        .data_i           (bayer_i.data),
        .frame_valid_o    (pan_frame_valid),
        .line_valid_o     (pan_line_valid),
        .pixel_valid_o    (pan_pixel_valid),
        .data_o           (pan_data)
    );

    assign pan_stream = '{
        frame_valid: pan_frame_valid,
        line_valid:  pan_line_valid,
        pixel_valid: pan_pixel_valid,
        data:        pan_data
    };

    debayer debayer0 (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_i          (pan_stream),
        .rgb_o            (debayer_rgb)
    );

    metering metering0 (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_i          (pan_stream),
        .stats_o          (stats_o),
        .stats_valid_o    (stats_valid_o)
    );

    digital_gain digital_gain0 (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .rgb_i            (debayer_rgb),
        .stats_i          (stats_o),
        .stats_valid_i    (stats_valid_o),
        .rgb_o            (gain_rgb)
    );

    crop #(
        .payload_t(rgb_t)
    ) zoom_crop (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .window_i         (zoom_window_i),
        .frame_valid_i    (gain_rgb.frame_valid),
        .line_valid_i     (gain_rgb.line_valid),
        .pixel_valid_i    (gain_rgb.pixel_valid),
        .data_i           (gain_rgb.pixel),
        .frame_valid_o    (zoom_frame_valid),
        .line_valid_o     (zoom_line_valid),
        .pixel_valid_o    (zoom_pixel_valid),
        .data_o           (zoom_pixel)
    );

    assign rgb_o = '{
        frame_valid: zoom_frame_valid,
        line_valid:  zoom_line_valid,
        pixel_valid: zoom_pixel_valid,
        pixel:       zoom_pixel
    };

endmodule

/* verif/camera_frontend_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the camera front end. Sends random
// RGGB frames with changing windows, predicts stats
// and RGB pixels with a model, and checks the DUT.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module camera_frontend_tb
    import camera_pkg::*;
();

    localparam int CLK_HALF     = 50;
    localparam int STIM_DELAY   = 10;     // Drive point after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 8;
    localparam int NUM_FRAMES   = 8;
    localparam int MAX_LEAD     = 5;
    localparam int MAX_LINE_GAP = 6;
    localparam int MAX_GAP      = 20;
    localparam int LATENCY      = 4;      // Input frame_valid to rgb_o frame_valid
    localparam int STATS_DELAY  = 2;      // Input frame_valid fall to stats_valid_o

    logic          mipi_byte_clock;
    logic          mipi_byte_reset_n;
    bayer_stream_t bayer;
    crop_window_t  pan_window;
    crop_window_t  zoom_window;
    rgb_stream_t   rgb;
    frame_stats_t  stats;
    logic          stats_valid;

    integer seed;
    int     cycle = 0;
    int     limit_cycles = 0;
    int     errors;
    int     checks;
    int     tests_done;
    int     frames_done;

    int frame_w [NUM_FRAMES];
    int frame_h [NUM_FRAMES];
    int frame_gap [NUM_FRAMES];
    int raw [24][40];                     // Current raw frame, row then column
    int pan_xs, pan_xe, pan_ys, pan_ye;
    int zoom_xs, zoom_xe, zoom_ys, zoom_ye;   // In quad units
    int prev_pix;
    int prev_dark;

    rgb_t         exp_pixel_q [$];
    frame_stats_t exp_stats_q [$];
    int           exp_count_q [$];
    int           exp_gain_q [$];
    int           in_rise_q [$];
    int           in_fall_q [$];

    logic out_fv_d;
    int   out_count;
    int   cur_exp_count;
    int   cur_gain;
    int   frame_err_start;

    camera_frontend dut0 (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_i          (bayer),
        .pan_window_i     (pan_window),
        .zoom_window_i    (zoom_window),
        .rgb_o            (rgb),
        .stats_o          (stats),
        .stats_valid_o    (stats_valid)
    );

    initial mipi_byte_clock = 1'b0;
    always #(CLK_HALF) mipi_byte_clock = ~mipi_byte_clock;

    always @(posedge mipi_byte_clock) cycle <= cycle + 1;

    function automatic int pick(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    // Gain of 1 or 2, clipped at full scale
    function automatic logic [PIXEL_WIDTH-1:0] scale_sample(input int sample, input int gain);
        int v;
        v = sample * gain;
        return (v > PIXEL_MAX) ? PIXEL_WIDTH'(PIXEL_MAX) : PIXEL_WIDTH'(v);
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_cycle(input logic fv, input logic lv, input logic pv, input int data);
        @(posedge mipi_byte_clock);
        #(STIM_DELAY);
        if (fv && !bayer.frame_valid) begin
            in_rise_q.push_back(cycle);
        end
        if (!fv && bayer.frame_valid) begin
            in_fall_q.push_back(cycle);
        end
        bayer.frame_valid = fv;
        bayer.line_valid  = lv;
        bayer.pixel_valid = pv;
        bayer.data        = PIXEL_WIDTH'(data);
    endtask

    // Frame sizes and gaps are drawn first to size the watchdog
    task automatic plan_frames();
        int total;
        total = RESET_CYCLES + IDLE_CYCLES + 50;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            frame_w[f]   = pick(24, 40);
            frame_h[f]   = pick(16, 24);
            frame_gap[f] = pick(10, MAX_GAP);
            total += frame_gap[f] + MAX_LEAD + frame_h[f] * (frame_w[f] + MAX_LINE_GAP) + 2;
        end
        limit_cycles = 2 * total;
    endtask

    task automatic fill_frame(input int f, input logic dark_frame);
        for (int y = 0; y < frame_h[f]; y++) begin
            for (int x = 0; x < frame_w[f]; x++) begin
                raw[y][x] = dark_frame ? pick(0, 255) : pick(0, PIXEL_MAX);
            end
        end
    endtask

    task automatic choose_windows(input int f);
        int qw;
        int qh;
        pan_xs  = 2 * pick(0, (frame_w[f] - 8) / 2);
        pan_xe  = pick(pan_xs + 8, frame_w[f]);
        pan_ys  = 2 * pick(0, (frame_h[f] - 6) / 2);
        pan_ye  = pick(pan_ys + 6, frame_h[f]);
        qw      = (pan_xe - pan_xs) / 2;             // Whole quads only
        qh      = (pan_ye - pan_ys) / 2;
        zoom_xs = 2 * pick(0, (qw - 1) / 2);
        zoom_xe = pick(zoom_xs + 1, qw);
        zoom_ys = 2 * pick(0, (qh - 1) / 2);
        zoom_ye = pick(zoom_ys + 1, qh);
    endtask

    task automatic build_model();
        int           pix;
        int           dark;
        int           gain;
        int           r0;
        int           c0;
        rgb_t         p;
        frame_stats_t s;
        pix  = (pan_xe - pan_xs) * (pan_ye - pan_ys);
        dark = 0;
        for (int y = pan_ys; y < pan_ye; y++) begin
            for (int x = pan_xs; x < pan_xe; x++) begin
                if ((raw[y][x] >> 2) < DARK_LEVEL) begin
                    dark++;
                end
            end
        end
        gain = (2 * prev_dark > prev_pix) ? 2 : 1;   // Previous frame decides
        for (int qy = zoom_ys; qy < zoom_ye; qy++) begin
            for (int qx = zoom_xs; qx < zoom_xe; qx++) begin
                r0      = pan_ys + 2 * qy;
                c0      = pan_xs + 2 * qx;
                p.red   = scale_sample(raw[r0][c0], gain);
                p.green = scale_sample((raw[r0][c0 + 1] + raw[r0 + 1][c0]) >> 1, gain);
                p.blue  = scale_sample(raw[r0 + 1][c0 + 1], gain);
                exp_pixel_q.push_back(p);
            end
        end
        s.pixel_count = COUNT_WIDTH'(pix);
        s.dark_count  = COUNT_WIDTH'(dark);
        exp_stats_q.push_back(s);
        exp_count_q.push_back((zoom_xe - zoom_xs) * (zoom_ye - zoom_ys));
        exp_gain_q.push_back(gain);
        prev_pix  = pix;
        prev_dark = dark;
    endtask

    task automatic drive_frame(input int f);
        int lead;
        int gap;
        lead = pick(2, MAX_LEAD);
        repeat (lead) drive_cycle(1'b1, 1'b0, 1'b0, 0);
        for (int y = 0; y < frame_h[f]; y++) begin
            for (int x = 0; x < frame_w[f]; x++) begin
                drive_cycle(1'b1, 1'b1, 1'b1, raw[y][x]);
            end
            gap = pick(2, MAX_LINE_GAP);
            repeat (gap) drive_cycle(1'b1, 1'b0, 1'b0, 0);
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 0);
    endtask

    task automatic check_idle();
        int err_start;
        err_start = errors;
        repeat (IDLE_CYCLES) begin
            @(negedge mipi_byte_clock);
            check_equal("rgb_o.frame_valid", 0, rgb.frame_valid);
            check_equal("rgb_o.line_valid", 0, rgb.line_valid);
            check_equal("rgb_o.pixel_valid", 0, rgb.pixel_valid);
            check_equal("stats_valid_o", 0, stats_valid);
        end
        tests_done++;
        $display("idle after reset: %0d errors", errors - err_start);
    endtask

    task automatic start_output_frame();
        int rise;
        frame_err_start = errors;
        out_count       = 0;
        checks++;
        assert (in_rise_q.size() > 0 && exp_count_q.size() > 0) else begin
            $display("Output frame started with no input frame left to match it");
            errors++;
        end
        if (in_rise_q.size() > 0 && exp_count_q.size() > 0) begin
            rise          = in_rise_q.pop_front();
            cur_exp_count = exp_count_q.pop_front();
            cur_gain      = exp_gain_q.pop_front();
            check_equal("rgb_o.frame_valid rise delay", LATENCY, cycle - rise);
        end
    endtask

    task automatic check_pixel();
        rgb_t p;
        out_count++;
        check_equal("rgb_o.line_valid", 1, rgb.line_valid);   // Strobe only inside a line
        checks++;
        assert (exp_pixel_q.size() > 0) else begin
            $display("rgb_o delivered a pixel that the model does not expect");
            errors++;
        end
        if (exp_pixel_q.size() > 0) begin
            p = exp_pixel_q.pop_front();
            check_equal("rgb_o.pixel.red", p.red, rgb.pixel.red);
            check_equal("rgb_o.pixel.green", p.green, rgb.pixel.green);
            check_equal("rgb_o.pixel.blue", p.blue, rgb.pixel.blue);
        end
    endtask

    task automatic check_stats();
        frame_stats_t s;
        int           fall;
        checks++;
        assert (exp_stats_q.size() > 0 && in_fall_q.size() > 0) else begin
            $display("stats_valid_o pulsed with no finished input frame");
            errors++;
        end
        if (exp_stats_q.size() > 0 && in_fall_q.size() > 0) begin
            s    = exp_stats_q.pop_front();
            fall = in_fall_q.pop_front();
            check_equal("stats_o.pixel_count", s.pixel_count, stats.pixel_count);
            check_equal("stats_o.dark_count", s.dark_count, stats.dark_count);
            check_equal("stats_valid_o delay", STATS_DELAY, cycle - fall);
        end
    endtask

    task automatic finish_output_frame();
        check_equal("rgb_o pixel count", cur_exp_count, out_count);
        $display("frame %0d: %0d rgb pixels, gain %0d, %0d errors",
                 frames_done, out_count, cur_gain, errors - frame_err_start);
        tests_done++;
        frames_done++;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge mipi_byte_clock) begin
        if (mipi_byte_reset_n) begin
            if (rgb.frame_valid && !out_fv_d) begin
                start_output_frame();
            end
            if (rgb.pixel_valid) begin
                check_pixel();
            end
            if (stats_valid) begin
                check_stats();
            end
            if (!rgb.frame_valid && out_fv_d) begin
                finish_output_frame();
            end
            out_fv_d = rgb.frame_valid;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge mipi_byte_clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic dark_frame;
        logic last_dark;
        logic clip_seen;
        seed              = 32'hcbe17ea6;
        mipi_byte_reset_n = 1'b0;
        bayer             = '0;
        pan_window        = '0;
        zoom_window       = '0;
        errors            = 0;
        checks            = 0;
        tests_done        = 0;
        frames_done       = 0;
        prev_pix          = 0;
        prev_dark         = 0;
        out_fv_d          = 1'b0;
        last_dark         = 1'b0;
        clip_seen         = 1'b0;
        plan_frames();

        repeat (RESET_CYCLES) @(posedge mipi_byte_clock);
        #(STIM_DELAY);
        mipi_byte_reset_n = 1'b1;
        check_idle();

        for (int f = 0; f < NUM_FRAMES; f++) begin
            dark_frame = pick(0, 1);
            if (f == NUM_FRAMES - 2 && !clip_seen) begin
                dark_frame = 1'b1;                  // Gain 2 for the last frame
            end
            if (f == NUM_FRAMES - 1 && !clip_seen) begin
                dark_frame = 1'b0;                  // Bright samples clip under gain 2
            end
            clip_seen = clip_seen | (last_dark & !dark_frame);
            last_dark = dark_frame;
            fill_frame(f, dark_frame);
            choose_windows(f);
            build_model();
            repeat (6) drive_cycle(1'b0, 1'b0, 1'b0, 0);   // Let the last frame drain
            pan_window  = '{x_start: COORD_WIDTH'(pan_xs), x_end: COORD_WIDTH'(pan_xe),
                            y_start: COORD_WIDTH'(pan_ys), y_end: COORD_WIDTH'(pan_ye)};
            zoom_window = '{x_start: COORD_WIDTH'(zoom_xs), x_end: COORD_WIDTH'(zoom_xe),
                            y_start: COORD_WIDTH'(zoom_ys), y_end: COORD_WIDTH'(zoom_ye)};
            repeat (frame_gap[f] - 6) drive_cycle(1'b0, 1'b0, 1'b0, 0);
            drive_frame(f);
        end

        wait (frames_done == NUM_FRAMES);
        repeat (8) @(posedge mipi_byte_clock);
        checks++;
        assert (exp_pixel_q.size() == 0 && exp_stats_q.size() == 0) else begin
            $display("Model still holds %0d pixels and %0d stats records at the end",
                     exp_pixel_q.size(), exp_stats_q.size());
            errors++;
        end

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/camera_pkg.sv
verilog/crop.sv
verilog/debayer.sv
verilog/metering.sv
verilog/digital_gain.sv
verilog/camera_frontend.sv
verif/camera_frontend_tb.sv

/* Bender.yml */
package:
  name: camera_frontend

sources:
  - verilog/camera_pkg.sv
  - verilog/crop.sv
  - verilog/debayer.sv
  - verilog/metering.sv
  - verilog/digital_gain.sv
  - verilog/camera_frontend.sv
  - target: test
    files:
      - verif/camera_frontend_tb.sv
